// ==== design/smi_pkg.sv ====
package smi_pkg;

    // ----------------------------------------------------------
    // frame format
    // ----------------------------------------------------------
    localparam int CMD_WRITE_BIT = 7;   // 1 = host write
    localparam int CMD_BLOCK_LSB = 5;
    localparam int CMD_BLOCK_W   = 2;
    localparam int IOC_W         = 5;
    localparam int DATA_W        = 8;
    localparam int FRAME_BITS    = 16;  // command byte + data byte

    // block select field of the command byte
    typedef enum logic [CMD_BLOCK_W-1:0] {
        BLK_SYS_CTRL   = 2'd0,
        BLK_TRACE_FIFO = 2'd1,
        BLK_UNUSED_2   = 2'd2,
        BLK_UNUSED_3   = 2'd3
    } smi_block_e;

    // host frame FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,     // shifting in the command byte
        ST_DECODE,  // command latched, fetch goes out here
        ST_DATA,    // second byte in flight
        ST_COMMIT   // load strobe for writes
    } frame_state_e;

endpackage

// ==== design/regmap_pkg.sv ====
package regmap_pkg;

    // ----------------------------------------------------------
    // IOC codes
    // ----------------------------------------------------------
    // codes are per block, so the fifo ones reuse sys_ctrl values
    typedef enum logic [smi_pkg::IOC_W-1:0] {
        IOC_MODULE_VERSION = 5'd0,  // read only
        IOC_SYSTEM_VERSION = 5'd1,  // read only
        IOC_MANU_ID        = 5'd2,  // read only
        IOC_ERROR_STATE    = 5'd3,  // read only, clears on read
        IOC_DEBUG_MODES    = 5'd5   // write only, reads 0
    } ioc_e;

    localparam ioc_e IOC_FIFO_DATA  = ioc_e'(5'd0);  // write pushes, read pops
    localparam ioc_e IOC_FIFO_LEVEL = ioc_e'(5'd1);  // read only

    // ----------------------------------------------------------
    // constant registers
    // ----------------------------------------------------------
    localparam logic [7:0] MODULE_VERSION = 8'h01;
    localparam logic [7:0] SYSTEM_VERSION = 8'h01;
    localparam logic [7:0] MANU_ID        = 8'h5c;

    // bits 7:4 of the error list read as zero
    localparam int ERR_FIFO_OVF    = 0;
    localparam int ERR_FIFO_UNF    = 1;
    localparam int ERR_BAD_BLOCK   = 2;
    localparam int ERR_SHORT_FRAME = 3;

endpackage

// ==== design/smi_shifter.sv ====
`timescale 1ns/100ps

module smi_shifter (
    input  logic                       i_sys_clk,
    input  logic                       i_rst_b,
    input  logic                       i_smi_cs_b,
    input  logic                       i_smi_clk,
    input  logic                       i_smi_mosi,
    input  logic                       i_tx_load,
    input  logic [smi_pkg::DATA_W-1:0] i_tx_byte,
    output logic                       o_smi_miso,
    output logic                       o_bit_strobe,
    output logic                       o_frame_start,
    output logic                       o_frame_end,
    output logic [smi_pkg::DATA_W-1:0] o_rx_byte
);
    import smi_pkg::*;

    logic [2:0]        cs_pipe;    // [1] synced, [2] previous
    logic [2:0]        clk_pipe;
    logic [1:0]        mosi_pipe;
    logic              cs_active;
    logic              clk_rise;
    logic              clk_fall;
    logic [DATA_W-1:0] tx_sr;
    logic              tx_hold;    // skip the fall right after a load

    assign cs_active  = ~cs_pipe[1];
    assign clk_rise   = clk_pipe[1] & ~clk_pipe[2];
    assign clk_fall   = ~clk_pipe[1] & clk_pipe[2];
    assign o_smi_miso = tx_sr[DATA_W-1];

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            cs_pipe       <= 3'b111;  // deselected
            clk_pipe      <= '0;
            mosi_pipe     <= '0;
            o_bit_strobe  <= 1'b0;
            o_frame_start <= 1'b0;
            o_frame_end   <= 1'b0;
            o_rx_byte     <= '0;
            tx_sr         <= '0;
            tx_hold       <= 1'b0;
        end else begin
            cs_pipe   <= {cs_pipe[1:0], i_smi_cs_b};
            clk_pipe  <= {clk_pipe[1:0], i_smi_clk};
            mosi_pipe <= {mosi_pipe[0], i_smi_mosi};

            o_bit_strobe  <= clk_rise & cs_active;
            o_frame_start <= cs_pipe[2] & ~cs_pipe[1];
            o_frame_end   <= ~cs_pipe[2] & cs_pipe[1];

            if (clk_rise && cs_active) begin
                o_rx_byte <= {o_rx_byte[DATA_W-2:0], mosi_pipe[1]};  // msb first
            end

            // msb sits on miso as soon as a byte is loaded
            if (o_frame_start) begin
                tx_sr   <= '0;
                tx_hold <= 1'b0;
            end else if (i_tx_load) begin
                tx_sr   <= i_tx_byte;
                tx_hold <= 1'b1;
            end else if (clk_fall && cs_active) begin
                if (tx_hold) begin
                    tx_hold <= 1'b0;
                end else begin
                    tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== design/frame_bit_counter.sv ====
`timescale 1ns/100ps

module frame_bit_counter (
    input  logic       i_sys_clk,
    input  logic       i_rst_b,
    input  logic       i_frame_start,
    input  logic       i_bit_strobe,
    output logic [4:0] o_bit_count,
    output logic       o_byte_done,
    output logic       o_second_byte
);
    import smi_pkg::*;

    logic at_limit;

    assign at_limit = (o_bit_count == 5'(FRAME_BITS));

    // strobe that completes bit 8 or bit 16
    assign o_byte_done   = i_bit_strobe &
                           ((o_bit_count == 5'(DATA_W - 1)) ||
                            (o_bit_count == 5'(FRAME_BITS - 1)));
    assign o_second_byte = (o_bit_count >= 5'(DATA_W));

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            o_bit_count <= '0;
        end else if (i_frame_start) begin
            o_bit_count <= '0;
        end else if (i_bit_strobe && !at_limit) begin
            o_bit_count <= o_bit_count + 5'd1;  // extra bits are dropped
        end
    end

endmodule

// ==== design/host_cmd_fsm.sv ====
`timescale 1ns/100ps

module host_cmd_fsm (
    input  logic                       i_sys_clk,
    input  logic                       i_rst_b,
    input  logic                       i_frame_start,
    input  logic                       i_frame_end,
    input  logic                       i_byte_done,
    input  logic                       i_second_byte,
    input  logic [smi_pkg::DATA_W-1:0] i_rx_byte,
    output logic                       o_cs_sys,
    output logic                       o_cs_fifo,
    output logic                       o_fetch_cmd,
    output logic                       o_load_cmd,
    output regmap_pkg::ioc_e           o_ioc,
    output logic                       o_tx_load,
    output logic                       o_frame_err,
    output smi_pkg::smi_block_e        o_block
);
    import smi_pkg::*;
    import regmap_pkg::*;

    frame_state_e      state;
    logic [DATA_W-1:0] cmd_q;       // command byte, held for the frame
    logic              cmd_wr;
    logic              cmd_seen;
    logic              blk_ok;
    logic              short_frame;

    assign cmd_wr  = cmd_q[CMD_WRITE_BIT];
    assign o_ioc   = ioc_e'(cmd_q[IOC_W-1:0]);
    assign o_block = smi_block_e'(cmd_q[CMD_BLOCK_LSB +: CMD_BLOCK_W]);
    assign blk_ok  = (o_block == BLK_SYS_CTRL) || (o_block == BLK_TRACE_FIFO);

    assign cmd_seen = (state == ST_DECODE) || (state == ST_DATA) || (state == ST_COMMIT);

    // ----------------------------------------------------------
    // strobes and selects
    // ----------------------------------------------------------
    assign o_cs_sys    = cmd_seen && (o_block == BLK_SYS_CTRL);
    assign o_cs_fifo   = cmd_seen && (o_block == BLK_TRACE_FIFO);
    assign o_fetch_cmd = (state == ST_DECODE) && !cmd_wr && blk_ok;
    assign o_load_cmd  = (state == ST_COMMIT) && cmd_wr && blk_ok;

    // select went high before all 16 bits were in
    assign short_frame = i_frame_end &&
                         ((state == ST_CMD) || (state == ST_DECODE) || (state == ST_DATA));
    assign o_frame_err = ((state == ST_DECODE) && !blk_ok) || short_frame;

    // ----------------------------------------------------------
    // state register
    // ----------------------------------------------------------
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            state     <= ST_IDLE;
            cmd_q     <= '0;
            o_tx_load <= 1'b0;
        end else begin
            o_tx_load <= o_fetch_cmd;  // read data is registered by then

            if (i_frame_start) begin
                state <= ST_CMD;
                cmd_q <= '0;
            end else begin
                case (state)
                    ST_CMD: begin
                        if (i_frame_end) begin
                            state <= ST_IDLE;
                        end else if (i_byte_done && !i_second_byte) begin
                            cmd_q <= i_rx_byte;
                            state <= ST_DECODE;
                        end
                    end
                    ST_DECODE: state <= i_frame_end ? ST_IDLE : ST_DATA;
                    ST_DATA: begin
                        if (i_frame_end) begin
                            state <= ST_IDLE;
                        end else if (i_byte_done && i_second_byte) begin
                            state <= ST_COMMIT;
                        end
                    end
                    default: state <= ST_IDLE;  // commit lasts one cycle
                endcase
            end
        end
    end

endmodule

// ==== design/sys_ctrl.sv ====
`timescale 1ns/100ps

module sys_ctrl (
    input  logic                       i_sys_clk,
    input  logic                       i_rst_b,
    input  regmap_pkg::ioc_e           i_ioc,
    input  logic [smi_pkg::DATA_W-1:0] i_data_in,
    output logic [smi_pkg::DATA_W-1:0] o_data_out,
    input  logic                       i_cs,
    input  logic                       i_fetch_cmd,
    input  logic                       i_load_cmd,
    input  logic [smi_pkg::DATA_W-1:0] i_err_set,
    output logic                       o_debug_fifo_push,
    output logic                       o_debug_fifo_pull,
    output logic                       o_debug_smi_test
);
    import smi_pkg::*;
    import regmap_pkg::*;

    logic [DATA_W-1:0] err_q;    // sticky error list
    logic              err_clr;

    assign err_clr = i_cs & i_fetch_cmd & (i_ioc == IOC_ERROR_STATE);

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            err_q             <= '0;
            o_debug_fifo_push <= 1'b0;
            o_debug_fifo_pull <= 1'b0;
            o_debug_smi_test  <= 1'b0;
        end else begin
            // new events win over the clear
            err_q <= (err_q & ~{DATA_W{err_clr}}) | i_err_set;
            if (i_cs && i_load_cmd && (i_ioc == IOC_DEBUG_MODES)) begin
                o_debug_fifo_push <= i_data_in[0];
                o_debug_fifo_pull <= i_data_in[1];
                o_debug_smi_test  <= i_data_in[2];
            end
        end
    end

    // ----------------------------------------------------------
    // read decode
    // ----------------------------------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (i_cs && i_fetch_cmd) begin
            case (i_ioc)
                IOC_MODULE_VERSION: o_data_out <= MODULE_VERSION;
                IOC_SYSTEM_VERSION: o_data_out <= SYSTEM_VERSION;
                IOC_MANU_ID:        o_data_out <= MANU_ID;
                IOC_ERROR_STATE:    o_data_out <= err_q;
                default:            o_data_out <= '0;  // debug modes too
            endcase
        end
    end

endmodule

// ==== design/debug_trace_fifo.sv ====
`timescale 1ns/100ps

module debug_trace_fifo #(
    parameter int FIFO_DEPTH = 8    // power of two
) (
    input  logic                       i_sys_clk,
    input  logic                       i_rst_b,
    input  regmap_pkg::ioc_e           i_ioc,
    input  logic [smi_pkg::DATA_W-1:0] i_data_in,
    output logic [smi_pkg::DATA_W-1:0] o_data_out,
    input  logic                       i_cs,
    input  logic                       i_fetch_cmd,
    input  logic                       i_load_cmd,
    input  logic                       i_snoop_en,
    input  logic                       i_peek,
    output logic                       o_overflow,
    output logic                       o_underflow
);
    import smi_pkg::*;
    import regmap_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       level;
    logic              full;
    logic              empty;
    logic              is_data;
    logic              push;
    logic              data_rd;
    logic              pop;

    assign full    = (level == (AW+1)'(FIFO_DEPTH));
    assign empty   = (level == '0);
    assign is_data = (i_ioc == IOC_FIFO_DATA);

    // snoop mode takes every host write, whatever the block
    assign push    = i_load_cmd & ((i_cs & is_data) | i_snoop_en);
    assign data_rd = i_cs & i_fetch_cmd & is_data;
    assign pop     = data_rd & ~i_peek;

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            level       <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
        end else begin
            o_overflow  <= push & full;   // byte dropped
            o_underflow <= pop & empty;
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
                level  <= level + 1'b1;
            end else if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
                level  <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (push && !full) begin
            mem[wr_ptr] <= i_data_in;
        end
        if (i_cs && i_fetch_cmd) begin
            if (is_data) begin
                o_data_out <= empty ? '0 : mem[rd_ptr];
            end else if (i_ioc == IOC_FIFO_LEVEL) begin
                o_data_out <= DATA_W'(level);
            end else begin
                o_data_out <= '0;
            end
        end
    end

endmodule

// ==== design/smi_ctrl_top.sv ====
`timescale 1ns/100ps

module smi_ctrl_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic i_sys_clk,
    input  logic i_rst_b,
    input  logic i_smi_cs_b,
    input  logic i_smi_clk,
    input  logic i_smi_mosi,
    output logic o_smi_miso,
    output logic o_debug_smi_test
);
    import smi_pkg::*;
    import regmap_pkg::*;

    logic              bit_strobe;
    logic              frame_start;
    logic              frame_end;
    logic [DATA_W-1:0] rx_byte;
    logic [DATA_W-1:0] tx_byte;
    logic              tx_load;
    logic              byte_done;
    logic              second_byte;
    logic              cs_sys;
    logic              cs_fifo;
    logic              fetch_cmd;
    logic              load_cmd;
    ioc_e              ioc;
    smi_block_e        block;
    logic              frame_err;
    logic              bad_block;
    logic [DATA_W-1:0] sys_data;
    logic [DATA_W-1:0] fifo_data;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] err_set;
    logic              fifo_ovf;
    logic              fifo_unf;
    logic              debug_fifo_push;
    logic              debug_fifo_pull;

    // ----------------------------------------------------------
    // read data mux
    // ----------------------------------------------------------
    assign rd_data   = (block == BLK_TRACE_FIFO) ? fifo_data : sys_data;
    assign tx_byte   = o_debug_smi_test ? rx_byte : rd_data;  // echo command byte
    assign bad_block = (block != BLK_SYS_CTRL) && (block != BLK_TRACE_FIFO);

    // a short frame after a bad select counts as bad block only
    always_comb begin
        err_set                  = '0;
        err_set[ERR_FIFO_OVF]    = fifo_ovf;
        err_set[ERR_FIFO_UNF]    = fifo_unf;
        err_set[ERR_BAD_BLOCK]   = frame_err & bad_block;
        err_set[ERR_SHORT_FRAME] = frame_err & ~bad_block;
    end

    smi_shifter u_shifter (
        .i_sys_clk     (i_sys_clk),
        .i_rst_b       (i_rst_b),
        .i_smi_cs_b    (i_smi_cs_b),
        .i_smi_clk     (i_smi_clk),
        .i_smi_mosi    (i_smi_mosi),
        .i_tx_load     (tx_load),
        .i_tx_byte     (tx_byte),
        .o_smi_miso    (o_smi_miso),
        .o_bit_strobe  (bit_strobe),
        .o_frame_start (frame_start),
        .o_frame_end   (frame_end),
        .o_rx_byte     (rx_byte)
    );

    frame_bit_counter u_bit_counter (
        .i_sys_clk     (i_sys_clk),
        .i_rst_b       (i_rst_b),
        .i_frame_start (frame_start),
        .i_bit_strobe  (bit_strobe),
        .o_bit_count   (),
        .o_byte_done   (byte_done),
        .o_second_byte (second_byte)
    );

    host_cmd_fsm u_cmd_fsm (
        .i_sys_clk     (i_sys_clk),
        .i_rst_b       (i_rst_b),
        .i_frame_start (frame_start),
        .i_frame_end   (frame_end),
        .i_byte_done   (byte_done),
        .i_second_byte (second_byte),
        .i_rx_byte     (rx_byte),
        .o_cs_sys      (cs_sys),
        .o_cs_fifo     (cs_fifo),
        .o_fetch_cmd   (fetch_cmd),
        .o_load_cmd    (load_cmd),
        .o_ioc         (ioc),
        .o_tx_load     (tx_load),
        .o_frame_err   (frame_err),
        .o_block       (block)
    );

    sys_ctrl u_sys_ctrl (
        .i_sys_clk         (i_sys_clk),
        .i_rst_b           (i_rst_b),
        .i_ioc             (ioc),
        .i_data_in         (rx_byte),
        .o_data_out        (sys_data),
        .i_cs              (cs_sys),
        .i_fetch_cmd       (fetch_cmd),
        .i_load_cmd        (load_cmd),
        .i_err_set         (err_set),
        .o_debug_fifo_push (debug_fifo_push),
        .o_debug_fifo_pull (debug_fifo_pull),
        .o_debug_smi_test  (o_debug_smi_test)
    );

    debug_trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_trace_fifo (
        .i_sys_clk   (i_sys_clk),
        .i_rst_b     (i_rst_b),
        .i_ioc       (ioc),
        .i_data_in   (rx_byte),
        .o_data_out  (fifo_data),
        .i_cs        (cs_fifo),
        .i_fetch_cmd (fetch_cmd),
        .i_load_cmd  (load_cmd),
        .i_snoop_en  (debug_fifo_push),
        .i_peek      (debug_fifo_pull),
        .o_overflow  (fifo_ovf),
        .o_underflow (fifo_unf)
    );

endmodule

// ==== dv/tb_smi_ctrl.sv ====
`timescale 1ns/100ps

module tb_smi_ctrl;
    import smi_pkg::*;
    import regmap_pkg::*;

    localparam int FIFO_DEPTH    = 4;
    localparam int HALF          = 8;   // sys clocks per smi half period
    localparam int RESET_CYCLES  = 16;

    logic   i_sys_clk;
    logic   i_rst_b;
    logic   i_smi_cs_b;
    logic   i_smi_clk;
    logic   i_smi_mosi;
    logic   o_smi_miso;
    logic   o_debug_smi_test;
    integer seed;

    logic [DATA_W-1:0] fifo_model[$];   // expected fifo contents

    smi_ctrl_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .i_sys_clk        (i_sys_clk),
        .i_rst_b          (i_rst_b),
        .i_smi_cs_b       (i_smi_cs_b),
        .i_smi_clk        (i_smi_clk),
        .i_smi_mosi       (i_smi_mosi),
        .o_smi_miso       (o_smi_miso),
        .o_debug_smi_test (o_debug_smi_test)
    );

    initial begin
        i_sys_clk = 1'b0;
        forever #20 i_sys_clk = ~i_sys_clk;
    end

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s read %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    // ----------------------------------------------------------
    // smi frame tasks
    // ----------------------------------------------------------
    task automatic sys_cycles(input int n);
        repeat (n) @(negedge i_sys_clk);
    endtask

    function automatic logic [DATA_W-1:0] make_cmd(input logic wr, input smi_block_e blk,
                                                   input ioc_e ioc);
        logic [DATA_W-1:0] cmd;
        cmd = '0;
        cmd[CMD_WRITE_BIT] = wr;
        cmd[CMD_BLOCK_LSB +: CMD_BLOCK_W] = blk;
        cmd[IOC_W-1:0] = ioc;
        return cmd;
    endfunction

    // host shifts msb first and samples miso on each rising smi clock
    task automatic shift_frame(input logic [FRAME_BITS-1:0] frame, input int nbits,
                               output logic [DATA_W-1:0] rd);
        logic [FRAME_BITS-1:0] frame_sr;
        int                    i;
        frame_sr = frame;
        rd = '0;
        @(negedge i_sys_clk);
        i_smi_cs_b = 1'b0;
        for (i = 0; i < nbits; i++) begin
            i_smi_mosi = frame_sr[FRAME_BITS-1];
            frame_sr   = frame_sr << 1;
            sys_cycles(HALF);
            i_smi_clk = 1'b1;
            if (i >= DATA_W) begin
                rd = {rd[DATA_W-2:0], o_smi_miso};  // data byte only
            end
            sys_cycles(HALF);
            i_smi_clk = 1'b0;
        end
        sys_cycles(HALF);
        i_smi_cs_b = 1'b1;
        i_smi_mosi = 1'b0;
        sys_cycles(2 * HALF);  // gap between frames
    endtask

    task automatic smi_write(input smi_block_e blk, input ioc_e ioc,
                             input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rd;
        shift_frame({make_cmd(1'b1, blk, ioc), data}, FRAME_BITS, unused_rd);
    endtask

    task automatic smi_read(input smi_block_e blk, input ioc_e ioc,
                            output logic [DATA_W-1:0] data);
        shift_frame({make_cmd(1'b0, blk, ioc), 8'h00}, FRAME_BITS, data);
    endtask

    task automatic smi_short_frame(input smi_block_e blk, input ioc_e ioc);
        logic [DATA_W-1:0] unused_rd;
        shift_frame({make_cmd(1'b0, blk, ioc), 8'h00}, 10, unused_rd);
    endtask

    // pop one byte and compare with the model, then the level
    task automatic pop_and_check(input string what);
        logic [DATA_W-1:0] rd;
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_DATA, rd);
        check_byte(what, rd, fifo_model.pop_front());
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_LEVEL, rd);
        check_byte("level after pop", rd, DATA_W'(fifo_model.size()));
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    task automatic test_const_regs();
        logic [DATA_W-1:0] rd;
        smi_read(BLK_SYS_CTRL, IOC_MODULE_VERSION, rd);
        check_byte("module version", rd, 8'h01);
        smi_read(BLK_SYS_CTRL, IOC_SYSTEM_VERSION, rd);
        check_byte("system version", rd, 8'h01);
        smi_read(BLK_SYS_CTRL, IOC_MANU_ID, rd);
        check_byte("manufacturer id", rd, 8'h5c);
        smi_read(BLK_SYS_CTRL, IOC_DEBUG_MODES, rd);
        check_byte("debug modes", rd, 8'h00);  // write only
    endtask

    task automatic test_smi_echo();
        logic [DATA_W-1:0] rd;
        smi_write(BLK_SYS_CTRL, IOC_DEBUG_MODES, 8'h04);
        check_level("smi test level", o_debug_smi_test, 1'b1);
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_LEVEL, rd);
        check_byte("echoed command", rd, make_cmd(1'b0, BLK_TRACE_FIFO, IOC_FIFO_LEVEL));
        smi_write(BLK_SYS_CTRL, IOC_DEBUG_MODES, 8'h00);
        check_level("smi test level", o_debug_smi_test, 1'b0);
    endtask

    task automatic test_fifo_order();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rd;
        int                n;
        for (n = 0; n < FIFO_DEPTH; n++) begin
            data = DATA_W'($random(seed));
            smi_write(BLK_TRACE_FIFO, IOC_FIFO_DATA, data);
            fifo_model.push_back(data);
            smi_read(BLK_TRACE_FIFO, IOC_FIFO_LEVEL, rd);
            check_byte("level after push", rd, DATA_W'(fifo_model.size()));
        end
        while (fifo_model.size() > 0) begin
            pop_and_check("fifo data in order");
        end
    endtask

    task automatic test_errors();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rd;
        int                n;
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_DATA, rd);
        check_byte("pop when empty", rd, 8'h00);
        for (n = 0; n <= FIFO_DEPTH; n++) begin
            data = DATA_W'($random(seed));
            smi_write(BLK_TRACE_FIFO, IOC_FIFO_DATA, data);
            if (n < FIFO_DEPTH) begin
                fifo_model.push_back(data);  // last one is dropped
            end
        end
        smi_read(BLK_UNUSED_3, IOC_MODULE_VERSION, rd);
        smi_short_frame(BLK_SYS_CTRL, IOC_MANU_ID);
        // ovf, unf, bad block, short frame
        smi_read(BLK_SYS_CTRL, IOC_ERROR_STATE, rd);
        check_byte("error state", rd, 8'h0f);
        smi_read(BLK_SYS_CTRL, IOC_ERROR_STATE, rd);
        check_byte("error state after clear", rd, 8'h00);
        while (fifo_model.size() > 0) begin
            pop_and_check("fifo data after overflow");
        end
    endtask

    task automatic test_snoop_peek();
        logic [DATA_W-1:0] rd;
        smi_write(BLK_SYS_CTRL, IOC_DEBUG_MODES, 8'h01);  // push on
        smi_write(BLK_SYS_CTRL, IOC_DEBUG_MODES, 8'h03);  // adds pull and is itself snooped
        fifo_model.push_back(8'h03);
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_LEVEL, rd);
        check_byte("level after snoop", rd, 8'h01);
        repeat (2) begin
            smi_read(BLK_TRACE_FIFO, IOC_FIFO_DATA, rd);
            check_byte("peeked data", rd, 8'h03);
        end
        smi_read(BLK_TRACE_FIFO, IOC_FIFO_LEVEL, rd);
        check_byte("level after peeks", rd, 8'h01);
        // push is still set while this write loads
        smi_write(BLK_SYS_CTRL, IOC_DEBUG_MODES, 8'h00);
        fifo_model.push_back(8'h00);
        while (fifo_model.size() > 0) begin
            pop_and_check("snooped data");
        end
    endtask

    initial begin
        seed       = 32'hc74a_2386;
        i_rst_b    = 1'b0;
        i_smi_cs_b = 1'b1;
        i_smi_clk  = 1'b0;
        i_smi_mosi = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_sys_clk);
        i_rst_b = 1'b1;
        sys_cycles(4);
        check_level("miso after reset", o_smi_miso, 1'b0);
        check_level("smi test after reset", o_debug_smi_test, 1'b0);

        test_const_regs();
        test_smi_echo();
        test_fifo_order();
        test_errors();
        test_snoop_peek();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
design/smi_pkg.sv
design/regmap_pkg.sv
design/smi_shifter.sv
design/frame_bit_counter.sv
design/host_cmd_fsm.sv
design/sys_ctrl.sv
design/debug_trace_fifo.sv
design/smi_ctrl_top.sv
dv/tb_smi_ctrl.sv

// ==== Makefile ====
SIM       := verilator
TOP       := tb_smi_ctrl
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing -j 0 --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
